/* rtl/mmioPkg.sv */
`default_nettype none

package mmioPkg;

    // Bus widths of the store-queue memory port
    localparam int ADDR_W = 30; // Word address, the byte offset is not on the bus
    localparam int DATA_W = 32;
    localparam int MASK_W = 4;

    localparam int GPIO_W = 16;

    // The low word-address bits pick a register inside the I/O page
    localparam int REG_IDX_W = 7;

    // Upper word-address bits that mark an access as I/O
    localparam logic [ADDR_W-REG_IDX_W-1:0] IO_BASE_WORD = 23'h7f_ffff;

    localparam logic [REG_IDX_W-1:0] REG_GPIO_OUT   = 7'd0;
    localparam logic [REG_IDX_W-1:0] REG_GPIO_OE    = 7'd1;
    localparam logic [REG_IDX_W-1:0] REG_GPIO_IN    = 7'd2; // Read only
    localparam logic [REG_IDX_W-1:0] REG_SPI_DATA   = 7'd4;
    localparam logic [REG_IDX_W-1:0] REG_SPI_STATUS = 7'd5; // Bit 0 is busy
    localparam logic [REG_IDX_W-1:0] REG_CYCLE_LO   = 7'd8;
    localparam logic [REG_IDX_W-1:0] REG_CYCLE_HI   = 7'd9;

    // System cycles per SPI clock half period
    localparam int SPI_DIV  = 2;
    localparam int SPI_BITS = 8;

    // Length of one whole transfer, which is also the length of the busy pulse
    localparam int SPI_XFER_CYCLES = SPI_DIV * 2 * SPI_BITS;

    // Phase counts the cycles of one SPI bit, both halves of the clock
    localparam int SPI_PHASE_W = $clog2(2 * SPI_DIV);
    localparam int SPI_BIT_W   = $clog2(SPI_BITS);

endpackage

`default_nettype wire

/* rtl/mmioDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module mmioDecode (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         writeEnable,
    input  wire [mmioPkg::ADDR_W-1:0]   writeAddr,
    input  wire [mmioPkg::MASK_W-1:0]   writeMask,
    input  wire                         readEnable,
    input  wire [mmioPkg::ADDR_W-1:0]   readAddr,
    input  wire [mmioPkg::GPIO_W-1:0]   gpioOutVal,
    input  wire [mmioPkg::GPIO_W-1:0]   gpioOeVal,
    input  wire [mmioPkg::GPIO_W-1:0]   gpioInVal,
    input  wire [mmioPkg::SPI_BITS-1:0] spiRxByte,
    input  wire                         spiBusy,
    input  wire [mmioPkg::DATA_W-1:0]   cycleLo,
    input  wire [mmioPkg::DATA_W-1:0]   cycleHi,
    output logic                        gpioOutWe,
    output logic                        gpioOeWe,
    output logic                        spiDataWe,
    output logic                        cycleLoWe,
    output logic [mmioPkg::DATA_W-1:0]  readData
);
    import mmioPkg::*;

    wire                 writeHit;
    wire                 readHit;
    wire [REG_IDX_W-1:0] writeIdx;
    wire [REG_IDX_W-1:0] readIdx;
    logic [DATA_W-1:0]   readMux;

    assign writeHit = writeEnable && (writeAddr[ADDR_W-1:REG_IDX_W] == IO_BASE_WORD);
    assign readHit  = readAddr[ADDR_W-1:REG_IDX_W] == IO_BASE_WORD;
    assign writeIdx = writeAddr[REG_IDX_W-1:0];
    assign readIdx  = readAddr[REG_IDX_W-1:0];

    // Writes to unmapped indices raise no strobe and are lost
    assign gpioOutWe = writeHit && (writeIdx == REG_GPIO_OUT);
    assign gpioOeWe  = writeHit && (writeIdx == REG_GPIO_OE);
    assign cycleLoWe = writeHit && (writeIdx == REG_CYCLE_LO);

    // The TX byte sits in byte lane 0, so a write without it starts nothing
    assign spiDataWe = writeHit && (writeIdx == REG_SPI_DATA) && writeMask[0];

    always_comb begin
        readMux = '0;
        if (readHit) begin
            case (readIdx)
                REG_GPIO_OUT:   readMux = DATA_W'(gpioOutVal);
                REG_GPIO_OE:    readMux = DATA_W'(gpioOeVal);
                REG_GPIO_IN:    readMux = DATA_W'(gpioInVal);
                REG_SPI_DATA:   readMux = DATA_W'(spiRxByte);
                REG_SPI_STATUS: readMux = DATA_W'(spiBusy);
                REG_CYCLE_LO:   readMux = cycleLo;
                REG_CYCLE_HI:   readMux = cycleHi;
                default:        readMux = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            readData <= '0;
        else if (readEnable)
            readData <= readMux; // Held until the next read
    end

endmodule

`default_nettype wire

/* rtl/gpioPort.sv */
`timescale 1ns/1ps
`default_nettype none

module gpioPort (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        outWe,
    input  wire                        oeWe,
    input  wire [mmioPkg::DATA_W-1:0]  writeData,
    input  wire [mmioPkg::MASK_W-1:0]  writeMask,
    input  wire [mmioPkg::GPIO_W-1:0]  gpioIn,
    output logic [mmioPkg::GPIO_W-1:0] gpioOut,
    output logic [mmioPkg::GPIO_W-1:0] gpioOe,
    output logic [mmioPkg::GPIO_W-1:0] gpioInSync
);
    import mmioPkg::*;

    logic [GPIO_W-1:0] gpioInMeta;

    // Only the low byte lanes map onto the port
    always_ff @(posedge clk) begin
        if (rst) begin
            gpioOut <= '0;
            gpioOe  <= '0;
        end else begin
            for (int i = 0; i < GPIO_W / 8; i++) begin
                if (outWe && writeMask[i])
                    gpioOut[i*8 +: 8] <= writeData[i*8 +: 8];
                if (oeWe && writeMask[i])
                    gpioOe[i*8 +: 8] <= writeData[i*8 +: 8];
            end
        end
    end

    // Pins are asynchronous to clk
    always_ff @(posedge clk) begin
        gpioInMeta <= gpioIn;
        gpioInSync <= gpioInMeta;
    end

endmodule

`default_nettype wire

/* rtl/spiMaster.sv */
`timescale 1ns/1ps
`default_nettype none

module spiMaster (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           start,
    input  wire [mmioPkg::SPI_BITS-1:0]   txByte,
    input  wire                           spiMiso,
    output logic                          busy,
    output logic [mmioPkg::SPI_BITS-1:0]  rxByte,
    output logic                          spiClk,
    output logic                          spiMosi
);
    import mmioPkg::*;

    logic [SPI_PHASE_W-1:0] phase; // Cycle inside the current bit
    logic [SPI_BIT_W-1:0]   bitCnt;
    logic [SPI_BITS-1:0]    shiftReg;
    wire                    riseNow;
    wire                    fallNow;
    wire                    lastCycle;

    // SPI clock goes high after the first half of a bit and low at its end
    assign riseNow = busy && (phase == SPI_PHASE_W'(SPI_DIV - 1));
    assign fallNow = busy && (phase == SPI_PHASE_W'(2 * SPI_DIV - 1));

    // Bit count above phase counts the cycles of the whole transfer
    assign lastCycle = busy &&
        ({bitCnt, phase} == (SPI_BIT_W + SPI_PHASE_W)'(SPI_XFER_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            spiClk  <= 1'b0;
            spiMosi <= 1'b0;
            phase   <= '0;
            bitCnt  <= '0;
            rxByte  <= '0;
        end else if (!busy) begin
            if (start) begin
                busy    <= 1'b1;
                spiMosi <= txByte[SPI_BITS-1]; // MSB is set up before the first rising edge
                phase   <= '0;
                bitCnt  <= '0;
            end
        end else begin
            phase <= phase + 1'b1;
            if (riseNow)
                spiClk <= 1'b1;
            if (fallNow) begin
                spiClk  <= 1'b0;
                bitCnt  <= bitCnt + 1'b1;
                spiMosi <= shiftReg[SPI_BITS-1]; // Next bit while the clock is low
            end
            if (lastCycle) begin
                busy    <= 1'b0;
                spiMosi <= 1'b0;
                rxByte  <= shiftReg;
            end
        end
    end

    // One register shifts the TX byte out and the RX byte in
    always_ff @(posedge clk) begin
        if (!busy && start)
            shiftReg <= txByte;
        else if (riseNow)
            shiftReg <= {shiftReg[SPI_BITS-2:0], spiMiso}; // Mode 0 samples on the rising edge
    end

endmodule

`default_nettype wire

/* rtl/cycleTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module cycleTimer (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        loadLo,
    input  wire [mmioPkg::DATA_W-1:0]  writeData,
    input  wire [mmioPkg::MASK_W-1:0]  writeMask,
    output logic [mmioPkg::DATA_W-1:0] cycleLo,
    output logic [mmioPkg::DATA_W-1:0] cycleHi
);
    import mmioPkg::*;

    logic [2*DATA_W-1:0] countNext;
    logic [DATA_W-1:0]   loLoaded;

    assign countNext = {cycleHi, cycleLo} + 1'b1;

    // Unwritten lanes still advance by one
    always_comb begin
        loLoaded = countNext[DATA_W-1:0];
        for (int i = 0; i < MASK_W; i++) begin
            if (writeMask[i])
                loLoaded[i*8 +: 8] = writeData[i*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cycleLo <= '0;
            cycleHi <= '0;
        end else if (loadLo) begin
            cycleLo <= loLoaded; // High word holds, even across a carry
        end else begin
            {cycleHi, cycleLo} <= countNext;
        end
    end

endmodule

`default_nettype wire

/* rtl/ioSubsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module ioSubsystem (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       writeEnable,
    input  wire [mmioPkg::ADDR_W-1:0] writeAddr,
    input  wire [mmioPkg::DATA_W-1:0] writeData,
    input  wire [mmioPkg::MASK_W-1:0] writeMask,
    input  wire                       readEnable,
    input  wire [mmioPkg::ADDR_W-1:0] readAddr,
    output wire [mmioPkg::DATA_W-1:0] readData,
    output wire                       ioBusy,
    output wire [mmioPkg::GPIO_W-1:0] gpioOut,
    output wire [mmioPkg::GPIO_W-1:0] gpioOe,
    input  wire [mmioPkg::GPIO_W-1:0] gpioIn,
    output wire                       spiClk,
    output wire                       spiMosi,
    input  wire                       spiMiso
);
    import mmioPkg::*;

    wire                gpioOutWe;
    wire                gpioOeWe;
    wire                spiDataWe;
    wire                cycleLoWe;
    wire [GPIO_W-1:0]   gpioInSync;
    wire [SPI_BITS-1:0] spiRxByte;
    wire [DATA_W-1:0]   cycleLo;
    wire [DATA_W-1:0]   cycleHi;

    mmioDecode u_mmioDecode (
        .clk         (clk),
        .rst         (rst),
        .writeEnable (writeEnable),
        .writeAddr   (writeAddr),
        .writeMask   (writeMask),
        .readEnable  (readEnable),
        .readAddr    (readAddr),
        .gpioOutVal  (gpioOut),
        .gpioOeVal   (gpioOe),
        .gpioInVal   (gpioInSync),
        .spiRxByte   (spiRxByte),
        .spiBusy     (ioBusy),
        .cycleLo     (cycleLo),
        .cycleHi     (cycleHi),
        .gpioOutWe   (gpioOutWe),
        .gpioOeWe    (gpioOeWe),
        .spiDataWe   (spiDataWe),
        .cycleLoWe   (cycleLoWe),
        .readData    (readData)
    );

    gpioPort u_gpioPort (
        .clk        (clk),
        .rst        (rst),
        .outWe      (gpioOutWe),
        .oeWe       (gpioOeWe),
        .writeData  (writeData),
        .writeMask  (writeMask),
        .gpioIn     (gpioIn),
        .gpioOut    (gpioOut),
        .gpioOe     (gpioOe),
        .gpioInSync (gpioInSync)
    );

    // Busy of the SPI engine is the only back-pressure seen by the store queue
    spiMaster u_spiMaster (
        .clk     (clk),
        .rst     (rst),
        .start   (spiDataWe),
        .txByte  (writeData[SPI_BITS-1:0]),
        .spiMiso (spiMiso),
        .busy    (ioBusy),
        .rxByte  (spiRxByte),
        .spiClk  (spiClk),
        .spiMosi (spiMosi)
    );

    cycleTimer u_cycleTimer (
        .clk       (clk),
        .rst       (rst),
        .loadLo    (cycleLoWe),
        .writeData (writeData),
        .writeMask (writeMask),
        .cycleLo   (cycleLo),
        .cycleHi   (cycleHi)
    );

endmodule

`default_nettype wire

/* sim/ioSubsystem_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module ioSubsystemAssert (
    input wire                       clk,
    input wire                       rst,
    input wire                       ioBusy,
    input wire                       spiClk,
    input wire                       spiMosi,
    input wire [mmioPkg::GPIO_W-1:0] gpioOut,
    input wire [mmioPkg::GPIO_W-1:0] gpioOe,
    input wire [mmioPkg::DATA_W-1:0] readData
);
    import mmioPkg::*;

    resetClears: assert property (
        @(posedge clk) rst |=> (gpioOut == '0) && (gpioOe == '0) && !spiClk && !spiMosi
                               && !ioBusy && (readData == '0)
    ) else $error("Control outputs not cleared in the cycle after reset");

    // Mode 0 keeps the SPI clock low between transfers
    clkIdleLow: assert property (
        @(posedge clk) disable iff (rst)
        !ioBusy |-> !spiClk
    ) else $error("spiClk high while no transfer is running");

    mosiStable: assert property (
        @(posedge clk) disable iff (rst)
        spiClk |-> $stable(spiMosi) // Data may only move on the falling half
    ) else $error("spiMosi changed while spiClk was high");

    busyLength: assert property (
        @(posedge clk) disable iff (rst)
        $rose(ioBusy) |-> ioBusy [*SPI_XFER_CYCLES] ##1 !ioBusy
    ) else $error("ioBusy pulse length differs from one SPI transfer");

endmodule

bind ioSubsystem ioSubsystemAssert u_ioSubsystemAssert (
    .clk      (clk),
    .rst      (rst),
    .ioBusy   (ioBusy),
    .spiClk   (spiClk),
    .spiMosi  (spiMosi),
    .gpioOut  (gpioOut),
    .gpioOe   (gpioOe),
    .readData (readData)
);

`default_nettype wire

/* sim/ioSubsystemTb.sv */
`timescale 1ns/1ps
`default_nettype none

module ioSubsystemTb;
    import mmioPkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int GPIO_LOOPS  = 20;
    localparam int GPIN_LOOPS  = 12;
    localparam int SPI_LOOPS   = 6;
    localparam int DROP_LOOPS  = 3;
    localparam int MISS_LOOPS  = 12;
    localparam int CYCLE_LOOPS = 8;

    // Worst case per access covers the longest random gap plus the handshake cycles
    localparam int SPI_XFERS    = SPI_LOOPS + DROP_LOOPS;
    localparam int ACCESSES     = 3 * GPIO_LOOPS + GPIN_LOOPS + 3 * SPI_LOOPS + 2 * DROP_LOOPS
                                  + 3 * MISS_LOOPS + 6 * CYCLE_LOOPS;
    localparam int WATCH_CYCLES = 2 * (SPI_XFERS * SPI_XFER_CYCLES + 24 * ACCESSES) + 100;

    logic                clk = 1'b0;
    logic                rst = 1'b1;
    logic                writeEnable = 1'b0;
    logic [ADDR_W-1:0]   writeAddr = '0;
    logic [DATA_W-1:0]   writeData = '0;
    logic [MASK_W-1:0]   writeMask = '0;
    logic                readEnable = 1'b0;
    logic [ADDR_W-1:0]   readAddr = '0;
    logic [GPIO_W-1:0]   gpioIn = '0;
    logic                spiMiso = 1'b0;
    wire  [DATA_W-1:0]   readData;
    wire                 ioBusy;
    wire  [GPIO_W-1:0]   gpioOut;
    wire  [GPIO_W-1:0]   gpioOe;
    wire                 spiClk;
    wire                 spiMosi;

    logic [31:0]         rngState;
    logic [GPIO_W-1:0]   modelOut = '0;
    logic [GPIO_W-1:0]   modelOe = '0;
    int                  busyRun = 0;

    ioSubsystem u_ioSubsystem (
        .clk         (clk),
        .rst         (rst),
        .writeEnable (writeEnable),
        .writeAddr   (writeAddr),
        .writeData   (writeData),
        .writeMask   (writeMask),
        .readEnable  (readEnable),
        .readAddr    (readAddr),
        .readData    (readData),
        .ioBusy      (ioBusy),
        .gpioOut     (gpioOut),
        .gpioOe      (gpioOe),
        .gpioIn      (gpioIn),
        .spiClk      (spiClk),
        .spiMosi     (spiMosi),
        .spiMiso     (spiMiso)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) spiMiso <= spiMosi; // One cycle of loopback delay stays inside a half bit

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [ADDR_W-1:0] regAddr(input logic [REG_IDX_W-1:0] idx);
        return {IO_BASE_WORD, idx};
    endfunction

    function automatic bit isMapped(input logic [REG_IDX_W-1:0] idx);
        return idx inside {REG_GPIO_OUT, REG_GPIO_OE, REG_GPIO_IN, REG_SPI_DATA,
                           REG_SPI_STATUS, REG_CYCLE_LO, REG_CYCLE_HI};
    endfunction

    // Byte lanes with their mask bit set take the new data
    function automatic logic [31:0] mergeLanes(input logic [31:0] base, input logic [31:0] data,
                                               input logic [MASK_W-1:0] mask);
        logic [31:0] result;
        result = base;
        for (int i = 0; i < MASK_W; i++) begin
            if (mask[i])
                result[i*8 +: 8] = data[i*8 +: 8];
        end
        return result;
    endfunction

    task automatic reportError(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic writeReg(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                            input logic [MASK_W-1:0] mask);
        @(posedge clk);
        writeEnable <= 1'b1;
        writeAddr   <= addr;
        writeData   <= data;
        writeMask   <= mask;
        @(posedge clk);
        writeEnable <= 1'b0;
        @(negedge clk);
    endtask

    task automatic readReg(input logic [ADDR_W-1:0] addr, output logic [31:0] data);
        @(posedge clk);
        readEnable <= 1'b1;
        readAddr   <= addr;
        @(posedge clk);
        readEnable <= 1'b0;
        @(negedge clk);
        data = readData;
    endtask

    task automatic expectRead(input logic [ADDR_W-1:0] addr, input logic [31:0] expected,
                              input string what);
        logic [31:0] got;
        readReg(addr, got);
        assert (got == expected)
            else reportError($sformatf("%s read 0x%08h, expected 0x%08h", what, got, expected));
        @(negedge clk);
        assert (readData == got) else reportError($sformatf("%s read data not held", what));
    endtask

    task automatic checkGpio();
        assert (gpioOut == modelOut && gpioOe == modelOe)
            else reportError($sformatf("GPIO out 0x%04h oe 0x%04h, expected 0x%04h 0x%04h",
                                       gpioOut, gpioOe, modelOut, modelOe));
    endtask

    task automatic waitIdle();
        int cycles;
        cycles = 0;
        while (ioBusy) begin
            @(negedge clk);
            cycles++;
            if (cycles > 2 * SPI_XFER_CYCLES)
                reportError("ioBusy stayed high far longer than one SPI transfer");
        end
    endtask

    // Every busy pulse is measured so that a dropped write cannot stretch it unseen
    always @(negedge clk) begin
        if (rst) begin
            busyRun = 0;
        end else if (ioBusy) begin
            // SPI clock is low in the first half of each bit and high in the second
            assert (spiClk == ((busyRun / SPI_DIV) % 2 == 1))
                else reportError($sformatf("spiClk %0b in cycle %0d of a transfer",
                                           spiClk, busyRun));
            busyRun++;
        end else if (busyRun != 0) begin
            assert (busyRun == SPI_XFER_CYCLES)
                else reportError($sformatf("ioBusy pulse lasted %0d cycles", busyRun));
            busyRun = 0;
        end
    end

    initial begin
        #(WATCH_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("TEST FAILED");
        $fatal(1, "Simulation timed out");
    end

    initial begin
        logic [31:0]          data;
        logic [31:0]          first;
        logic [31:0]          second;
        logic [31:0]          hiBefore;
        logic [MASK_W-1:0]    mask;
        logic [REG_IDX_W-1:0] idx;
        logic [ADDR_W-1:0]    addr;
        int                   gap;
        rngState = 32'h543c0c3d;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (gpioOut == '0 && gpioOe == '0 && !ioBusy && !spiClk && !spiMosi && readData == '0)
            else reportError("Outputs not cleared by reset");

        for (int i = 0; i < GPIO_LOOPS; i++) begin
            data = nextRandom();
            mask = MASK_W'(nextRandom());
            idx  = (nextRandom() & 32'd1) != 0 ? REG_GPIO_OE : REG_GPIO_OUT;
            writeReg(regAddr(idx), data, mask);
            if (idx == REG_GPIO_OUT)
                modelOut = GPIO_W'(mergeLanes(32'(modelOut), data, mask));
            else
                modelOe = GPIO_W'(mergeLanes(32'(modelOe), data, mask));
            checkGpio();
            expectRead(regAddr(REG_GPIO_OUT), 32'(modelOut), "GPIO_OUT");
            expectRead(regAddr(REG_GPIO_OE), 32'(modelOe), "GPIO_OE");
        end

        for (int i = 0; i < GPIN_LOOPS; i++) begin
            data = nextRandom();
            @(posedge clk);
            gpioIn <= data[GPIO_W-1:0];
            repeat (3) @(posedge clk);
            expectRead(regAddr(REG_GPIO_IN), 32'(data[GPIO_W-1:0]), "GPIO_IN");
        end

        for (int i = 0; i < SPI_LOOPS; i++) begin
            data = nextRandom();
            mask = MASK_W'(nextRandom()) | 4'h1;
            writeReg(regAddr(REG_SPI_DATA), data, mask);
            assert (ioBusy) else reportError("ioBusy did not rise after a write to SPI_DATA");
            expectRead(regAddr(REG_SPI_STATUS), 32'd1, "SPI_STATUS during transfer");
            waitIdle();
            expectRead(regAddr(REG_SPI_DATA), 32'(data[7:0]), "SPI_DATA loopback");
            expectRead(regAddr(REG_SPI_STATUS), 32'd0, "SPI_STATUS after transfer");
        end

        for (int i = 0; i < DROP_LOOPS; i++) begin
            first  = nextRandom();
            second = first ^ (nextRandom() | 32'd1); // Low bit always differs
            writeReg(regAddr(REG_SPI_DATA), first, 4'hf);
            writeReg(regAddr(REG_SPI_DATA), second, 4'hf);
            assert (ioBusy) else reportError("Transfer ended right after a dropped write");
            waitIdle();
            expectRead(regAddr(REG_SPI_DATA), 32'(first[7:0]), "SPI_DATA after dropped write");
        end

        for (int i = 0; i < MISS_LOOPS; i++) begin
            data = nextRandom();
            mask = MASK_W'(nextRandom());
            if (i % 2 == 0) begin
                addr = regAddr(REG_IDX_W'(nextRandom() % 10));
                addr[ADDR_W-1:REG_IDX_W] = addr[ADDR_W-1:REG_IDX_W]
                                           ^ ((ADDR_W-REG_IDX_W)'(nextRandom()) | 23'd1);
            end else begin
                idx = REG_IDX_W'(nextRandom());
                while (isMapped(idx))
                    idx = idx + 7'd1;
                addr = regAddr(idx);
            end
            writeReg(addr, data, mask);
            checkGpio();
            assert (!ioBusy) else reportError("A missed write started an SPI transfer");
            expectRead(addr, 32'd0, "Unmapped address");
        end

        for (int i = 0; i < CYCLE_LOOPS; i++) begin
            gap = int'(nextRandom() % 16);
            readReg(regAddr(REG_CYCLE_LO), first);
            repeat (gap) @(posedge clk);
            readReg(regAddr(REG_CYCLE_LO), second);
            assert (second - first == 32'(gap + 2))
                else reportError($sformatf("Counter advanced %0d in %0d cycles",
                                           second - first, gap + 2));
        end

        for (int i = 0; i < CYCLE_LOOPS; i++) begin
            gap  = int'(nextRandom() % 16);
            data = nextRandom() & 32'h7fff_ffff; // Keeps the low word far from a wrap
            mask = MASK_W'(nextRandom());
            readReg(regAddr(REG_CYCLE_HI), hiBefore);
            readReg(regAddr(REG_CYCLE_LO), first);
            writeReg(regAddr(REG_CYCLE_LO), data, mask);
            repeat (gap) @(posedge clk);
            // Two cycles pass between the sampled read and the load edge
            expectRead(regAddr(REG_CYCLE_LO), mergeLanes(first + 32'd3, data, mask) + 32'(gap + 1),
                       "CYCLE_LO after a load");
            expectRead(regAddr(REG_CYCLE_HI), hiBefore, "CYCLE_HI after a load");
        end

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
rtl/mmioPkg.sv
rtl/mmioDecode.sv
rtl/gpioPort.sv
rtl/spiMaster.sv
rtl/cycleTimer.sv
rtl/ioSubsystem.sv
sim/ioSubsystem_assert.sv
sim/ioSubsystemTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; the exit status reflects pass or fail
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module ioSubsystemTb -f list.f -o ioSubsystemSim \
    && ./obj_dir/ioSubsystemSim | tee /dev/stderr | grep "^TEST OK$" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
